/* src/mixer_pkg.sv */
/* Opcode encoding, instruction field layout and pipeline depth shared by the mixer RTL.
   Field widths are fixed by the 32-bit instruction word. */
package mixer_pkg;

    // Opcode field values, anything else is illegal
    typedef enum logic [7:0] {
        OP_NOOP    = 8'd0,
        OP_CAPTURE = 8'd1,
        OP_SAVE    = 8'd2,
        OP_MAC     = 8'd8,
        OP_MACZ    = 8'd9,
        OP_MACN    = 8'd10,
        OP_MACNZ   = 8'd11,
        OP_HALT    = 8'd15
    } mix_op_t;

    // Word widths
    localparam int INSTR_W   = 32;
    localparam int SAMPLE_W  = 16;
    localparam int GAIN_W    = 16;
    localparam int SLOT_W    = 4;
    localparam int CAPTURE_W = 32;

    // Instruction word layout
    localparam int OP_LSB     = 24;
    localparam int OP_W       = 8;
    localparam int OFFSET_LSB = 20;
    localparam int OFFSET_W   = 4;
    localparam int CHAN_LSB   = 16;
    localparam int GAIN_LSB   = 0;

    // Cycles from fetch of an instruction to its output write
    localparam int PIPE_DEPTH = 9;

endpackage

/* src/coef_store.sv */
/* Program RAM, one instruction per word, read data one cycle after the address.
   Host writes during a run change that run in an undefined way. */
`timescale 1ns/1ps

module coef_store #(
    parameter int CODE_W = 8
) (
    input  logic                         ck,
    input  logic                         we,
    input  logic [CODE_W-1:0]            waddr,
    input  logic [mixer_pkg::INSTR_W-1:0] wdata,
    input  logic [CODE_W-1:0]            raddr,
    output logic [mixer_pkg::INSTR_W-1:0] rdata
);
    import mixer_pkg::*;

    logic [INSTR_W-1:0] mem [2**CODE_W];

    // Host write port
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Sequencer fetch port
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

/* src/audio_buffer.sv */
/* Per-channel circular delay line of samples, addressed as {chan, frame}.
   The host writes the current frame; taps read back one cycle after the address. */
`timescale 1ns/1ps

module audio_buffer #(
    parameter int CHAN_W  = 4,
    parameter int FRAME_W = 4
) (
    input  logic                          ck,
    input  logic                          we,
    input  logic [CHAN_W-1:0]             wchan,
    input  logic [FRAME_W-1:0]            frame,
    input  logic [mixer_pkg::SAMPLE_W-1:0] wdata,
    input  logic [CHAN_W+FRAME_W-1:0]     raddr,
    output logic [mixer_pkg::SAMPLE_W-1:0] rdata
);
    import mixer_pkg::*;

    localparam int ADDR_W = CHAN_W + FRAME_W;

    logic [SAMPLE_W-1:0] mem [2**ADDR_W];

    // Newest sample of a channel lands at the current frame index,
    // overwriting the oldest one
    always_ff @(posedge ck) begin
        if (we) begin
            mem[{wchan, frame}] <= wdata;
        end
    end

    // Tap read for the MAC datapath
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

/* src/mac_datapath.sv */
/* Sign-magnitude multiply and signed accumulate, four cycles from sample to out_we.
   SAVE output is truncated, no saturation. */
`timescale 1ns/1ps

module mac_datapath #(
    parameter int ACC_W = 40
) (
    input  logic                           ck,
    input  logic                           reset,
    input  logic [mixer_pkg::SAMPLE_W-1:0]  sample,
    input  logic [mixer_pkg::GAIN_W-1:0]    gain,
    input  logic                           acc_en,
    input  logic                           acc_clear,
    input  logic                           acc_sub_req,
    input  logic                           shift_en,
    input  logic                           capture_en,
    input  logic [mixer_pkg::OFFSET_W-1:0]  shift_amt,
    input  logic [mixer_pkg::SLOT_W-1:0]    out_slot,
    output logic                           out_we,
    output logic [mixer_pkg::SLOT_W-1:0]    out_addr,
    output logic [mixer_pkg::SAMPLE_W-1:0]  out_audio,
    output logic [mixer_pkg::CAPTURE_W-1:0] capture_out
);
    import mixer_pkg::*;

    localparam int PROD_W = GAIN_W + SAMPLE_W;

    // Sign split stage
    logic [SAMPLE_W-1:0] mag_1;
    logic [GAIN_W-1:0]   gain_1;
    logic                neg_1, acc_en_1, clear_1, sub_1, shift_1, cap_1;
    logic [OFFSET_W-1:0] amt_1;
    logic [SLOT_W-1:0]   slot_1;

    // Multiply stage
    logic [PROD_W-1:0]   prod_2;
    logic                acc_en_2, clear_2, sub_2, shift_2, cap_2;
    logic [OFFSET_W-1:0] amt_2;
    logic [SLOT_W-1:0]   slot_2;

    // Accumulate stage
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] prod_ext;
    logic signed [ACC_W-1:0] acc_shifted;
    logic                    shift_3, cap_3;
    logic [OFFSET_W-1:0]     amt_3;
    logic [SLOT_W-1:0]       slot_3;

    // Output stage
    logic [SAMPLE_W-1:0] audio_4;
    logic [SLOT_W-1:0]   slot_4;

    // Negative samples become a magnitude; the sign flips add and subtract later
    always_ff @(posedge ck) begin
        mag_1  <= sample[SAMPLE_W-1] ? SAMPLE_W'(-sample) : sample;
        gain_1 <= gain;
        amt_1  <= shift_amt;
        slot_1 <= out_slot;
        if (reset) begin
            neg_1    <= 1'b0;
            acc_en_1 <= 1'b0;
            clear_1  <= 1'b0;
            sub_1    <= 1'b0;
            shift_1  <= 1'b0;
            cap_1    <= 1'b0;
        end else begin
            neg_1    <= sample[SAMPLE_W-1];
            acc_en_1 <= acc_en;
            clear_1  <= acc_clear;
            sub_1    <= acc_sub_req;
            shift_1  <= shift_en;
            cap_1    <= capture_en;
        end
    end

    always_ff @(posedge ck) begin
        prod_2 <= mag_1 * gain_1;
        amt_2  <= amt_1;
        slot_2 <= slot_1;
        if (reset) begin
            acc_en_2 <= 1'b0;
            clear_2  <= 1'b0;
            sub_2    <= 1'b0;
            shift_2  <= 1'b0;
            cap_2    <= 1'b0;
        end else begin
            acc_en_2 <= acc_en_1;
            clear_2  <= clear_1;
            sub_2    <= sub_1 ^ neg_1;
            shift_2  <= shift_1;
            cap_2    <= cap_1;
        end
    end

    assign prod_ext = signed'({{(ACC_W-PROD_W){1'b0}}, prod_2});

    always_ff @(posedge ck) begin
        amt_3  <= amt_2;
        slot_3 <= slot_2;
        if (reset) begin
            acc     <= '0;
            shift_3 <= 1'b0;
            cap_3   <= 1'b0;
        end else begin
            shift_3 <= shift_2;
            cap_3   <= cap_2;
            if (acc_en_2) begin
                if (clear_2) begin
                    acc <= sub_2 ? -prod_ext : prod_ext;
                end else begin
                    acc <= sub_2 ? acc - prod_ext : acc + prod_ext;
                end
            end
        end
    end

    // Slice bits 16+amt up, sign filling above the accumulator top
    assign acc_shifted = acc >>> (SAMPLE_W + amt_3);

    always_ff @(posedge ck) begin
        audio_4 <= acc_shifted[SAMPLE_W-1:0];
        slot_4  <= slot_3;
        if (reset) begin
            out_we      <= 1'b0;
            capture_out <= '0;
        end else begin
            out_we <= shift_3;
            if (cap_3) begin
                capture_out <= acc[CAPTURE_W-1:0];
            end
        end
    end

    // Output bus idles at zero between writes
    assign out_audio = out_we ? audio_4 : '0;
    assign out_addr  = out_we ? slot_4 : '0;

endmodule

/* src/mix_sequencer.sv */
/* Fetch, decode and tap addressing for the MAC pipeline; start is ignored while busy.
   The offset field is 4 bits, so FRAME_W is expected to be 4. */
`timescale 1ns/1ps

module mix_sequencer #(
    parameter int CODE_W  = 8,
    parameter int CHAN_W  = 4,
    parameter int FRAME_W = 4
) (
    input  logic                         ck,
    input  logic                         reset,
    input  logic                         start,
    input  logic [FRAME_W-1:0]           frame,
    input  logic [mixer_pkg::INSTR_W-1:0] coef_rdata,
    output logic [CODE_W-1:0]            coef_raddr,
    output logic [CHAN_W+FRAME_W-1:0]    tap_addr,
    output logic                         busy,
    output logic                         done,
    output logic                         error,
    output logic                         acc_en,
    output logic                         acc_clear,
    output logic                         acc_sub_req,
    output logic                         shift_en,
    output logic                         capture_en,
    output logic [FRAME_W-1:0]           shift_amt,
    output logic [mixer_pkg::GAIN_W-1:0]  gain,
    output logic [mixer_pkg::SLOT_W-1:0]  out_slot
);
    import mixer_pkg::*;

    // HALT reaches decode two cycles after its fetch
    localparam int DRAIN_W    = $clog2(PIPE_DEPTH);
    localparam int DRAIN_LOAD = PIPE_DEPTH - 3;

    logic                start_ok, halt_now;
    logic                fetching, rd_valid, ir_valid;
    logic [CODE_W-1:0]   pc;
    logic [INSTR_W-1:0]  ir;
    mix_op_t             op;
    logic [DRAIN_W-1:0]  drain;

    logic dec_mac, dec_zero, dec_neg, dec_save, dec_cap, dec_halt, dec_illegal;

    // Decode and execute stage registers
    logic                d_mac, d_zero, d_neg, d_save, d_cap;
    logic [CHAN_W-1:0]   d_chan;
    logic [FRAME_W-1:0]  d_off;
    logic [GAIN_W-1:0]   d_gain;
    logic                e_mac, e_zero, e_neg, e_save, e_cap;
    logic [FRAME_W-1:0]  e_off;
    logic [GAIN_W-1:0]   e_gain;

    assign start_ok   = start && !busy;
    assign halt_now   = ir_valid && dec_halt;
    assign coef_raddr = pc;
    assign op         = mix_op_t'(ir[OP_LSB +: OP_W]);

    // Address 0 sits on the bus while idle, so the start cycle fetches it
    always_ff @(posedge ck) begin
        if (reset) begin
            pc <= '0;
        end else if (start_ok) begin
            pc <= CODE_W'(1);
        end else if (fetching && !halt_now) begin
            pc <= pc + 1'b1;
        end else begin
            pc <= '0;
        end
    end

    // Valid bits squash whatever was fetched behind a HALT
    always_ff @(posedge ck) begin
        ir <= coef_rdata;
        if (reset) begin
            rd_valid <= 1'b0;
            ir_valid <= 1'b0;
        end else begin
            rd_valid <= start_ok || (fetching && !halt_now);
            ir_valid <= rd_valid && !halt_now;
        end
    end

    always_comb begin
        dec_mac     = 1'b0;
        dec_zero    = 1'b0;
        dec_neg     = 1'b0;
        dec_save    = 1'b0;
        dec_cap     = 1'b0;
        dec_halt    = 1'b0;
        dec_illegal = 1'b0;
        case (op)
            OP_NOOP:    ;
            OP_CAPTURE: dec_cap = 1'b1;
            OP_SAVE:    dec_save = 1'b1;
            OP_MAC:     dec_mac = 1'b1;
            OP_MACZ: begin
                dec_mac  = 1'b1;
                dec_zero = 1'b1;
            end
            OP_MACN: begin
                dec_mac = 1'b1;
                dec_neg = 1'b1;
            end
            OP_MACNZ: begin
                dec_mac  = 1'b1;
                dec_zero = 1'b1;
                dec_neg  = 1'b1;
            end
            OP_HALT:    dec_halt = 1'b1;
            default:    dec_illegal = 1'b1;
        endcase
    end

    // Run state; done comes one cycle after the drain count reaches one
    always_ff @(posedge ck) begin
        if (reset) begin
            fetching <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            error    <= 1'b0;
            drain    <= '0;
        end else begin
            if (start_ok) begin
                fetching <= 1'b1;
                busy     <= 1'b1;
                done     <= 1'b0;
                error    <= 1'b0;
            end
            if (halt_now) begin
                fetching <= 1'b0;
                drain    <= DRAIN_W'(DRAIN_LOAD);
            end else if (drain != '0) begin
                drain <= drain - 1'b1;
            end
            if (drain == DRAIN_W'(1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (ir_valid && dec_illegal) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge ck) begin
        d_chan <= ir[CHAN_LSB +: CHAN_W];
        d_off  <= ir[OFFSET_LSB +: FRAME_W];
        d_gain <= ir[GAIN_LSB +: GAIN_W];
        if (reset) begin
            {d_mac, d_zero, d_neg, d_save, d_cap} <= '0;
        end else begin
            d_mac  <= ir_valid && dec_mac;
            d_zero <= dec_zero;
            d_neg  <= dec_neg;
            d_save <= ir_valid && dec_save;
            d_cap  <= ir_valid && dec_cap;
        end
    end

    // Offset 0 is the newest sample, frame index wraps
    always_ff @(posedge ck) begin
        tap_addr <= {d_chan, frame - d_off};
        e_off    <= d_off;
        e_gain   <= d_gain;
        if (reset) begin
            {e_mac, e_zero, e_neg, e_save, e_cap} <= '0;
        end else begin
            {e_mac, e_zero, e_neg, e_save, e_cap} <= {d_mac, d_zero, d_neg, d_save, d_cap};
        end
    end

    // Controls line up with tap_data at the datapath input
    always_ff @(posedge ck) begin
        shift_amt <= e_off;
        gain      <= e_gain;
        out_slot  <= e_gain[SLOT_W-1:0];
        if (reset) begin
            acc_en      <= 1'b0;
            acc_clear   <= 1'b0;
            acc_sub_req <= 1'b0;
            shift_en    <= 1'b0;
            capture_en  <= 1'b0;
        end else begin
            acc_en      <= e_mac;
            acc_clear   <= e_mac && e_zero;
            acc_sub_req <= e_mac && e_neg;
            shift_en    <= e_save;
            capture_en  <= e_cap;
        end
    end

endmodule

/* src/audio_mixer.sv */
/* Mixer top: program RAM, sample delay lines, sequencer and MAC datapath.
   Host writes use plain strobes; output slots appear only as a write strobe. */
`timescale 1ns/1ps

module audio_mixer #(
    parameter int CODE_W  = 8,
    parameter int CHAN_W  = 4,
    parameter int FRAME_W = 4,
    parameter int ACC_W   = 40
) (
    input  logic                           ck,
    input  logic                           reset,
    input  logic                           coef_we,
    input  logic [CODE_W-1:0]              coef_waddr,
    input  logic [mixer_pkg::INSTR_W-1:0]   coef_wdata,
    input  logic                           audio_we,
    input  logic [CHAN_W-1:0]              audio_wchan,
    input  logic [mixer_pkg::SAMPLE_W-1:0]  audio_wdata,
    input  logic [FRAME_W-1:0]             frame,
    input  logic                           start,
    output logic                           busy,
    output logic                           done,
    output logic                           error,
    output logic                           out_we,
    output logic [mixer_pkg::SLOT_W-1:0]    out_addr,
    output logic [mixer_pkg::SAMPLE_W-1:0]  out_audio,
    output logic [mixer_pkg::CAPTURE_W-1:0] capture_out
);
    import mixer_pkg::*;

    logic [CODE_W-1:0]         coef_raddr;
    logic [INSTR_W-1:0]        coef_rdata;
    logic [CHAN_W+FRAME_W-1:0] tap_addr;
    logic [SAMPLE_W-1:0]       tap_data;
    logic                      acc_en, acc_clear, acc_sub_req, shift_en, capture_en;
    logic [FRAME_W-1:0]        shift_amt;
    logic [GAIN_W-1:0]         gain;
    logic [SLOT_W-1:0]         out_slot;

    coef_store #(.CODE_W(CODE_W)) i_coef_store (
        .ck(ck), .we(coef_we), .waddr(coef_waddr), .wdata(coef_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    audio_buffer #(.CHAN_W(CHAN_W), .FRAME_W(FRAME_W)) i_audio_buffer (
        .ck(ck), .we(audio_we), .wchan(audio_wchan), .frame(frame), .wdata(audio_wdata),
        .raddr(tap_addr), .rdata(tap_data)
    );

    mix_sequencer #(.CODE_W(CODE_W), .CHAN_W(CHAN_W), .FRAME_W(FRAME_W)) i_mix_sequencer (
        .ck(ck), .reset(reset), .start(start), .frame(frame), .coef_rdata(coef_rdata),
        .coef_raddr(coef_raddr), .tap_addr(tap_addr),
        .busy(busy), .done(done), .error(error),
        .acc_en(acc_en), .acc_clear(acc_clear), .acc_sub_req(acc_sub_req),
        .shift_en(shift_en), .capture_en(capture_en),
        .shift_amt(shift_amt), .gain(gain), .out_slot(out_slot)
    );

    mac_datapath #(.ACC_W(ACC_W)) i_mac_datapath (
        .ck(ck), .reset(reset), .sample(tap_data), .gain(gain),
        .acc_en(acc_en), .acc_clear(acc_clear), .acc_sub_req(acc_sub_req),
        .shift_en(shift_en), .capture_en(capture_en),
        .shift_amt(shift_amt), .out_slot(out_slot),
        .out_we(out_we), .out_addr(out_addr), .out_audio(out_audio),
        .capture_out(capture_out)
    );

endmodule

/* tb/tb_clock.sv */
/* Free-running testbench clock; reset is released on a falling edge
   after RESET_CYCLES rising edges. */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic ck,
    output logic reset
);

    initial begin
        ck = 1'b0;
        forever #(PERIOD / 2) ck = ~ck;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge ck);
        @(negedge ck);
        reset = 1'b0;
    end

endmodule

/* tb/audio_mixer_tb.sv */
/* Directed tests of the mixer against a behavioral model of the instruction rules.
   Inputs change and outputs are sampled on the falling edge. */
`timescale 1ns/1ps

module audio_mixer_tb;
    import mixer_pkg::*;

    // Program words of all runs; margin covers reset, buffer fill and sample writes
    localparam int PROG_WORDS      = 3 + 6 + 8 + 5 + 4 + 3 + 4 * 10;
    localparam int WATCHDOG_CYCLES = PROG_WORDS * PIPE_DEPTH + 1000;

    logic        ck;
    logic        reset;
    logic        coef_we;
    logic [7:0]  coef_waddr;
    logic [31:0] coef_wdata;
    logic        audio_we;
    logic [3:0]  audio_wchan;
    logic [15:0] audio_wdata;
    logic [3:0]  frame;
    logic        start;
    logic        busy, done, error, out_we;
    logic [3:0]  out_addr;
    logic [15:0] out_audio;
    logic [31:0] capture_out;

    int          cyc;
    logic [31:0] lcg_state;
    logic [31:0] prog [$];
    logic [15:0] model_mem [256];
    int          exp_addr [$];
    logic [3:0]  exp_slot [$];
    logic [15:0] exp_data [$];
    int          got_cycle [$];
    logic [3:0]  got_slot [$];
    logic [15:0] got_data [$];
    logic [31:0] exp_cap;
    logic        exp_cap_valid, exp_err;
    int          halt_addr;
    int          test_errors, total_errors, tests_run, tests_failed;

    tb_clock #(.PERIOD(40), .RESET_CYCLES(16)) i_tb_clock (.ck(ck), .reset(reset));

    audio_mixer #(.CODE_W(8), .CHAN_W(4), .FRAME_W(4), .ACC_W(40)) i_audio_mixer (
        .ck(ck), .reset(reset),
        .coef_we(coef_we), .coef_waddr(coef_waddr), .coef_wdata(coef_wdata),
        .audio_we(audio_we), .audio_wchan(audio_wchan), .audio_wdata(audio_wdata),
        .frame(frame), .start(start), .busy(busy), .done(done), .error(error),
        .out_we(out_we), .out_addr(out_addr), .out_audio(out_audio),
        .capture_out(capture_out)
    );

    initial cyc = 0;
    always @(posedge ck) cyc <= cyc + 1;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ck);
        $display("Watchdog expired after %0d cycles, DUT never finished", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc(input logic [7:0] op, input int off, input int chan,
                                        input int g);
        return {op, off[3:0], chan[3:0], g[15:0]};
    endfunction

    task automatic report_mismatch(input string name, input string what, input longint exp,
                                   input longint act);
        $display("Error: %s %s expected %0d actual %0d", name, what, exp, act);
        test_errors++;
    endtask

    task automatic report_failure(input string name, input string msg);
        $display("%s: %s", name, msg);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic write_sample(input int chan, input int fr, input logic [15:0] value);
        audio_wchan = chan[3:0];
        frame       = fr[3:0];
        audio_wdata = value;
        audio_we    = 1'b1;
        @(negedge ck);
        audio_we = 1'b0;
        model_mem[{chan[3:0], fr[3:0]}] = value;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            coef_we    = 1'b1;
            coef_waddr = i[7:0];
            coef_wdata = prog[i];
            @(negedge ck);
        end
        coef_we = 1'b0;
    endtask

    // Walks the program up to HALT with a wide signed accumulator
    task automatic compute_model(input int fr);
        longint             acc;
        longint             term;
        longint             shifted;
        logic [7:0]         op;
        logic [3:0]         off, chan, tap_frame;
        logic [15:0]        g;
        logic signed [15:0] s;
        exp_addr      = {};
        exp_slot      = {};
        exp_data      = {};
        exp_cap_valid = 1'b0;
        exp_err       = 1'b0;
        halt_addr     = -1;
        acc           = 0;
        for (int i = 0; i < prog.size() && halt_addr < 0; i++) begin
            {op, off, chan, g} = prog[i];
            tap_frame = fr[3:0] - off;
            s         = model_mem[{chan, tap_frame}];
            term      = longint'(g) * longint'(s);
            case (op)
                OP_NOOP:    ;
                OP_MAC:     acc = acc + term;
                OP_MACZ:    acc = term;
                OP_MACN:    acc = acc - term;
                OP_MACNZ:   acc = -term;
                OP_SAVE: begin
                    shifted = acc >>> (16 + off);
                    exp_addr.push_back(i);
                    exp_slot.push_back(g[3:0]);
                    exp_data.push_back(shifted[15:0]);
                end
                OP_CAPTURE: begin
                    exp_cap       = acc[31:0];
                    exp_cap_valid = 1'b1;
                end
                OP_HALT:    halt_addr = i;
                default:    exp_err = 1'b1;
            endcase
        end
    endtask

    // Loads, starts and checks one run; poke gives a second start pulse while busy
    task automatic run_program(input string name, input int fr, input int poke);
        int start_cyc;
        load_program();
        frame = fr[3:0];
        compute_model(fr);
        got_cycle = {};
        got_slot  = {};
        got_data  = {};
        start     = 1'b1;
        start_cyc = cyc;
        @(negedge ck);
        start = 1'b0;
        while (!done) begin
            if (out_we) begin
                got_cycle.push_back(cyc);
                got_slot.push_back(out_addr);
                got_data.push_back(out_audio);
            end else if (out_addr != 0 || out_audio != 0) begin
                report_failure(name, "output bus not zero while out_we is low");
            end
            start = (poke > 0 && cyc == start_cyc + poke);
            @(negedge ck);
        end
        start = 1'b0;
        if (cyc != start_cyc + halt_addr + PIPE_DEPTH)
            report_mismatch(name, "done cycle", start_cyc + halt_addr + PIPE_DEPTH, cyc);
        if (busy)
            report_failure(name, "busy still high when done rose");
        if (error !== exp_err)
            report_mismatch(name, "error", exp_err, error);
        repeat (4) begin
            @(negedge ck);
            if (out_we)
                report_failure(name, "output write seen after done");
        end
        if (got_data.size() != exp_data.size())
            report_mismatch(name, "write count", exp_data.size(), got_data.size());
        for (int k = 0; k < got_data.size() && k < exp_data.size(); k++) begin
            if (got_slot[k] != exp_slot[k])
                report_mismatch(name, "slot", exp_slot[k], got_slot[k]);
            if (got_data[k] != exp_data[k])
                report_mismatch(name, "sample", exp_data[k], got_data[k]);
            if (got_cycle[k] != start_cyc + exp_addr[k] + PIPE_DEPTH)
                report_mismatch(name, "write cycle", start_cyc + exp_addr[k] + PIPE_DEPTH,
                                got_cycle[k]);
        end
        if (exp_cap_valid && capture_out != exp_cap)
            report_mismatch(name, "capture", exp_cap, capture_out);
    endtask

    task automatic fill_buffer();
        logic [31:0] r;
        for (int a = 0; a < 256; a++) begin
            r = lcg_next();
            write_sample(a / 16, a % 16, r[31:16]);
        end
    endtask

    task automatic test_single_tap();
        write_sample(3, 2, 16'd1234);
        prog = {enc(OP_MACZ, 0, 3, 16'h4000), enc(OP_SAVE, 0, 0, 5), enc(OP_HALT, 0, 0, 0)};
        run_program("single_tap", 2, 0);
        // 1234 * 0x4000 >> 16
        if (got_data.size() > 0 && got_data[0] != 16'd308)
            report_mismatch("single_tap", "hand value", 308, got_data[0]);
        finish_test("single_tap");
    endtask

    task automatic test_multi_tap();
        write_sample(1, 7, -16'sd2000);
        write_sample(2, 5, 16'sd3000);
        write_sample(4, 6, -16'sd32768);
        write_sample(1, 14, 16'sd12345);
        // Offset 9 from frame 7 wraps to frame 14
        prog = {enc(OP_MACZ, 0, 1, 16'h8000), enc(OP_MAC, 2, 2, 16'h2000),
                enc(OP_MACN, 1, 4, 16'h0100), enc(OP_MAC, 9, 1, 16'h1234),
                enc(OP_SAVE, 1, 0, 9), enc(OP_HALT, 0, 0, 0)};
        run_program("multi_tap", 7, 0);
        finish_test("multi_tap");
    endtask

    task automatic test_back_to_back();
        write_sample(0, 3, 16'sd1000);
        write_sample(5, 1, -16'sd700);
        write_sample(6, 3, 16'sd20000);
        prog = {enc(OP_MACZ, 0, 0, 16'h7fff), enc(OP_SAVE, 0, 0, 1),
                enc(OP_MAC, 2, 5, 16'h1000), enc(OP_MACN, 0, 6, 16'h0800),
                enc(OP_SAVE, 0, 0, 2), enc(OP_HALT, 0, 0, 0),
                enc(OP_SAVE, 0, 0, 3), enc(OP_SAVE, 0, 0, 4)};
        run_program("back_to_back", 3, 0);
        finish_test("back_to_back");
    endtask

    task automatic test_capture();
        write_sample(7, 9, -16'sd12000);
        write_sample(8, 8, 16'sd321);
        prog = {enc(OP_MACNZ, 0, 7, 16'hffff), enc(OP_MAC, 1, 8, 16'h3000),
                enc(OP_CAPTURE, 0, 0, 0), enc(OP_MAC, 0, 7, 16'h1000),
                enc(OP_HALT, 0, 0, 0)};
        run_program("capture", 9, 0);
        finish_test("capture");
    endtask

    task automatic test_illegal_opcode();
        prog = {enc(OP_MACZ, 0, 7, 16'h0100), enc(8'h55, 0, 0, 0),
                enc(OP_SAVE, 0, 0, 7), enc(OP_HALT, 0, 0, 0)};
        run_program("illegal_opcode", 9, 4);
        if (error !== 1'b1)
            report_failure("illegal_opcode", "error not raised by unknown opcode");
        prog = {enc(OP_MACZ, 1, 8, 16'h0100), enc(OP_SAVE, 0, 0, 6), enc(OP_HALT, 0, 0, 0)};
        run_program("illegal_opcode", 9, 0);
        finish_test("illegal_opcode");
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] q;
        for (int f = 10; f < 14; f++) begin
            for (int ch = 0; ch < 16; ch++) begin
                r = lcg_next();
                write_sample(ch, f, r[31:16]);
            end
            prog = {};
            // First tap clears what the previous run left in the accumulator
            for (int t = 0; t < 8; t++) begin
                r = lcg_next();
                q = lcg_next();
                prog.push_back(enc(8'(OP_MAC) + {r[31], r[30] | (t == 0)},
                                   r[29:26], r[25:22], q[31:16]));
            end
            r = lcg_next();
            prog.push_back(enc(OP_SAVE, r[31:30], 0, r[29:26]));
            prog.push_back(enc(OP_HALT, 0, 0, 0));
            run_program("random", f, 0);
        end
        finish_test("random");
    endtask

    initial begin
        coef_we      = 1'b0;
        coef_waddr   = '0;
        coef_wdata   = '0;
        audio_we     = 1'b0;
        audio_wchan  = '0;
        audio_wdata  = '0;
        frame        = '0;
        start        = 1'b0;
        lcg_state    = 32'h19a0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        @(negedge ck);
        while (reset !== 1'b0) @(negedge ck);
        if (out_we !== 1'b0 || done !== 1'b0 || error !== 1'b0 || busy !== 1'b0)
            report_failure("reset_state", "status or out_we not low after reset");
        if (capture_out !== 32'd0)
            report_mismatch("reset_state", "capture", 0, capture_out);
        finish_test("reset_state");
        fill_buffer();
        test_single_tap();
        test_multi_tap();
        test_back_to_back();
        test_capture();
        test_illegal_opcode();
        test_random();
        $display("Tests run: %0d, tests with errors: %0d, check errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* audio_mixer.f */
src/mixer_pkg.sv
src/coef_store.sv
src/audio_buffer.sv
src/mac_datapath.sv
src/mix_sequencer.sv
src/audio_mixer.sv
tb/tb_clock.sv
tb/audio_mixer_tb.sv

/* Bender.yml */
package:
  name: audio_mixer

sources:
  - src/mixer_pkg.sv
  - src/coef_store.sv
  - src/audio_buffer.sv
  - src/mac_datapath.sv
  - src/mix_sequencer.sv
  - src/audio_mixer.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/audio_mixer_tb.sv
